//--- verilog/mem_ctrl_defines.svh
// array geometry and field widths shared by the memory controller RTL
// include in any file that sizes ports or registers from the PE array shape
`ifndef MEM_CTRL_DEFINES_SVH
`define MEM_CTRL_DEFINES_SVH

// PE array shape, one map buffer word holds MC_COLS points
`define MC_COLS          8
`define MC_ROWS          16

// buffer address widths
`define MAP_AW           9
`define WT_AW            14

// convolution layers handled by the controller, numbered from 1
`define NUM_CONV_LAYERS  7
`define LYR_W            4

// layer parameter field widths
`define PRM_W            12
`define CH_W             7
`define KS_W             8
`define PK_W             4
`define PS_W             3
`define RELU_W           2

// derived loop bound widths
`define SPAN_W           10
`define BM_W             7
`define CAL_W            10
`define FTN_W            4
`define CYC_W            11

`endif

//--- verilog/mem_ctrl_pkg.sv
// layer parameter tables and helpers for the memory controller
// imported by the decode, read sequencer and weight address blocks
`default_nettype none
`include "mem_ctrl_defines.svh"

package mem_ctrl_pkg;

	// field positions inside one layer_tbl row
	localparam int unsigned LT_IX     = 0;
	localparam int unsigned LT_OXC    = 1;
	localparam int unsigned LT_M      = 2;
	localparam int unsigned LT_N      = 3;
	localparam int unsigned LT_HU     = 4;
	localparam int unsigned LT_K      = 5;
	localparam int unsigned LT_S      = 6;
	localparam int unsigned LT_PK     = 7;
	localparam int unsigned LT_PS     = 8;
	localparam int unsigned LT_RELU   = 9;
	localparam int unsigned LT_PAD    = 10;
	localparam int unsigned LT_FIELDS = 11;

	// width for intermediate address products
	localparam int unsigned MUL_W = 20;
	// input window moves by 2*S words per calculation pass
	localparam int unsigned WIN_STEP = 2;

	// IX, OX after conv, M, N, Hu, K, S, pool K, pool S, relu max, input pad
	localparam int unsigned layer_tbl [1:`NUM_CONV_LAYERS][0:LT_FIELDS-1] = '{
		'{3600, 1800,  1,  8, 46, 16, 2, 8, 4, 2, 14},
		'{ 449,  225,  8, 12, 42, 12, 2, 4, 2, 2, 11},
		'{ 111,  111, 12, 32, 24,  9, 1, 5, 2, 0,  8},
		'{  54,   54, 32, 64, 22,  7, 1, 4, 2, 0,  6},
		'{  26,   26, 64, 64, 20,  5, 1, 2, 2, 0,  4},
		'{  13,   13, 64, 64, 18,  3, 1, 2, 2, 0,  2},
		'{   6,    6, 64, 72, 18,  3, 1, 2, 2, 0,  2}
	};

	// first weight buffer word of each layer
	localparam int unsigned wt_base_tbl [1:`NUM_CONV_LAYERS] = '{
		0, 16, 208, 640, 2432, 4992, 6528
	};

	// points to whole buffer words, rounded up
	function automatic int unsigned words_of(input int unsigned pts);
		return (pts + `MC_COLS - 1) / `MC_COLS;
	endfunction

endpackage

`default_nettype wire

//--- verilog/layer_param_decode.sv
// latches one convolution layer's parameters from the package table on load
// and derives the loop bounds used by the read sequencer and weight generator
`timescale 1ns/1ps
`default_nettype none
`include "mem_ctrl_defines.svh"

module layer_param_decode (
	input  logic                  clk_cal,
	input  logic                  rst_cal_n,
	input  logic                  param_load,
	input  logic [`LYR_W-1:0]     nn_layer_cnt,
	output logic [`KS_W-1:0]      k,
	output logic [`KS_W-1:0]      s,
	output logic [`CH_W-1:0]      m,
	output logic [`PK_W-1:0]      pool_k,
	output logic [`PS_W-1:0]      pool_s,
	output logic [`RELU_W-1:0]    relu_max,
	output logic [`CYC_W-1:0]     cal_cycle,
	output logic [`CYC_W-1:0]     pass_cycle,
	output logic [`SPAN_W-1:0]    imap_span,
	output logic [`BM_W-1:0]      bm_times,
	output logic [`BM_W-1:0]      bm_times1,
	output logic [`CAL_W-1:0]     cal_times,
	output logic [`FTN_W-1:0]     ft_n_times,
	output logic [`WT_AW-1:0]     wt_base
);
	import mem_ctrl_pkg::*;

	logic [`LYR_W-1:0]  lyr_idx;
	logic [`PRM_W-1:0]  pad_ix;
	logic [`PRM_W-1:0]  oxc;
	logic [`SPAN_W-1:0] span_d;
	logic [`BM_W-1:0]   bm_d;
	logic [`CAL_W-1:0]  cal_d;
	logic [`FTN_W-1:0]  ftn_d;

	// layer index outside 1..7 falls back to layer 1
	assign lyr_idx = (nn_layer_cnt >= `LYR_W'(1) &&
		nn_layer_cnt <= `LYR_W'(`NUM_CONV_LAYERS)) ? nn_layer_cnt : `LYR_W'(1);

	// ***********************************************************
	// loop bounds from the selected table row
	// ***********************************************************
	always_comb begin
		// input map length including zero padding at both ends
		pad_ix = `PRM_W'(layer_tbl[lyr_idx][LT_IX] + layer_tbl[lyr_idx][LT_PAD]);
		oxc    = `PRM_W'(layer_tbl[lyr_idx][LT_OXC]);
		// words of one padded map in the map buffer
		span_d = `SPAN_W'(words_of(pad_ix));
		// Hu points per burst
		bm_d   = `BM_W'(words_of(layer_tbl[lyr_idx][LT_HU]));
		// output channels go MC_COLS per fetch
		ftn_d  = `FTN_W'(words_of(layer_tbl[lyr_idx][LT_N]));
		// each pass yields MC_ROWS outputs, last layer is a single pass
		if (lyr_idx == `LYR_W'(`NUM_CONV_LAYERS))
			cal_d = `CAL_W'(1);
		else
			cal_d = `CAL_W'((oxc + `MC_ROWS - 1) / `MC_ROWS);
	end

	// ***********************************************************
	// parameter registers, stable from the cycle after the load
	// ***********************************************************
	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n) begin
			k          <= '0;
			s          <= '0;
			m          <= '0;
			pool_k     <= '0;
			pool_s     <= '0;
			relu_max   <= '0;
			wt_base    <= '0;
			imap_span  <= '0;
			bm_times   <= '0;
			bm_times1  <= '0;
			cal_times  <= '0;
			ft_n_times <= '0;
		end else if (param_load) begin
			k          <= `KS_W'(layer_tbl[lyr_idx][LT_K]);
			s          <= `KS_W'(layer_tbl[lyr_idx][LT_S]);
			m          <= `CH_W'(layer_tbl[lyr_idx][LT_M]);
			pool_k     <= `PK_W'(layer_tbl[lyr_idx][LT_PK]);
			pool_s     <= `PS_W'(layer_tbl[lyr_idx][LT_PS]);
			relu_max   <= `RELU_W'(layer_tbl[lyr_idx][LT_RELU]);
			wt_base    <= `WT_AW'(wt_base_tbl[lyr_idx]);
			imap_span  <= span_d;
			bm_times   <= bm_d;
			// one extra word for the input register file enable
			bm_times1  <= bm_d + 1'b1;
			cal_times  <= cal_d;
			ft_n_times <= ftn_d;
		end
	end

	// MACs per output point, k taps over m input maps
	assign cal_cycle  = `CYC_W'(k) * `CYC_W'(m);
	// pipeline fill through the rows and the column skew
	assign pass_cycle = `CYC_W'(`MC_ROWS + `MC_COLS - 3) + `CYC_W'(k);

endmodule

`default_nettype wire

//--- verilog/map_read_sequencer.sv
// nested burst, map, fetch and pass counters for reading one layer's input maps
// drives the map buffer read address, the output valids and the done flags
`timescale 1ns/1ps
`default_nettype none
`include "mem_ctrl_defines.svh"

module map_read_sequencer (
	input  logic                  clk_cal,
	input  logic                  rst_cal_n,
	input  logic                  cal_start,
	input  logic                  cal_active,
	input  logic                  pe_end,
	input  logic [`SPAN_W-1:0]    imap_span,
	input  logic [`BM_W-1:0]      bm_times,
	input  logic [`BM_W-1:0]      bm_times1,
	input  logic [`CAL_W-1:0]     cal_times,
	input  logic [`FTN_W-1:0]     ft_n_times,
	input  logic [`CH_W-1:0]      m,
	input  logic [`KS_W-1:0]      s,
	output logic [`BM_W-1:0]      bm_cnt,
	output logic [`CH_W-1:0]      m_cnt,
	output logic [`FTN_W-1:0]     ft_n_cnt,
	output logic [`MAP_AW-1:0]    rd_addr,
	output logic                  rd_done,
	output logic                  data_o_vld,
	output logic                  data_o_vld1,
	output logic                  rd_lyr_done
);
	import mem_ctrl_pkg::*;

	logic [`CAL_W-1:0]  cal_cnt;
	logic               burst_adv;
	logic               burst_end;
	logic               m_last;
	logic               ftn_last;
	logic               lyr_last;
	logic [MUL_W-1:0]   map_off;
	logic [MUL_W-1:0]   win_off;
	logic [`MAP_AW-1:0] rd_addr_nxt;

	// PE array takes a word this cycle
	assign burst_adv = pe_end && cal_active && !rd_lyr_done;
	// last word of the burst goes out
	assign burst_end = burst_adv && (bm_cnt == bm_times);
	assign m_last    = (m_cnt == m);
	assign ftn_last  = (ft_n_cnt == ft_n_times);
	assign lyr_last  = m_last && ftn_last && (cal_cnt == cal_times);

	// ***********************************************************
	// burst word counter
	// ***********************************************************
	// a dropped pe_end restarts the burst from word 0
	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n)
			bm_cnt <= '0;
		else if (cal_start || !burst_adv || burst_end)
			bm_cnt <= '0;
		else
			bm_cnt <= bm_cnt + 1'b1;
	end

	// one pulse per completed burst
	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n)
			rd_done <= 1'b0;
		else
			rd_done <= burst_end;
	end

	// ***********************************************************
	// map, fetch and pass counters, m_cnt innermost
	// ***********************************************************
	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n) begin
			m_cnt    <= '0;
			ft_n_cnt <= '0;
			cal_cnt  <= '0;
		end else if (cal_start) begin
			m_cnt    <= `CH_W'(1);
			ft_n_cnt <= `FTN_W'(1);
			cal_cnt  <= `CAL_W'(1);
		end else if (rd_done) begin
			m_cnt <= m_last ? `CH_W'(1) : m_cnt + 1'b1;
			if (m_last)
				ft_n_cnt <= ftn_last ? `FTN_W'(1) : ft_n_cnt + 1'b1;
			// pass count holds at its bound once the layer is read
			if (m_last && ftn_last && cal_cnt != cal_times)
				cal_cnt <= cal_cnt + 1'b1;
		end
	end

	// set after the final burst, cleared by the next layer start
	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n)
			rd_lyr_done <= 1'b0;
		else if (cal_start)
			rd_lyr_done <= 1'b0;
		else if (rd_done && lyr_last)
			rd_lyr_done <= 1'b1;
	end

	// ***********************************************************
	// output valids and read address
	// ***********************************************************
	// valid for every word of the burst but the last one
	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n) begin
			data_o_vld  <= 1'b0;
			data_o_vld1 <= 1'b0;
		end else begin
			data_o_vld  <= burst_adv && (bm_cnt != bm_times);
			data_o_vld1 <= burst_adv && (bm_cnt != bm_times1);
		end
	end

	// map base, then window start of the pass, then word in burst
	assign map_off = (MUL_W'(m_cnt) - MUL_W'(1)) * MUL_W'(imap_span);
	assign win_off = (MUL_W'(cal_cnt) - MUL_W'(1)) * MUL_W'(WIN_STEP) * MUL_W'(s);
	assign rd_addr_nxt = `MAP_AW'(map_off + win_off + MUL_W'(bm_cnt));

	always_ff @(posedge clk_cal) begin
		if (pe_end)
			rd_addr <= rd_addr_nxt;
	end

endmodule

`default_nettype wire

//--- verilog/weight_addr_gen.sv
// weight buffer addressing during calculation, one k-word window per burst
// column 0 address and valid, then a skew line feeding the other PE columns
`timescale 1ns/1ps
`default_nettype none
`include "mem_ctrl_defines.svh"

module weight_addr_gen (
	input  logic                               clk_cal,
	input  logic                               rst_cal_n,
	input  logic                               cal_start,
	input  logic                               cal_active,
	input  logic                               pe_end,
	input  logic                               rd_done,
	input  logic [`CH_W-1:0]                   m_cnt,
	input  logic [`FTN_W-1:0]                  ft_n_cnt,
	input  logic [`KS_W-1:0]                   k,
	input  logic [`CH_W-1:0]                   m,
	input  logic [`FTN_W-1:0]                  ft_n_times,
	input  logic [`WT_AW-1:0]                  wt_base,
	output logic [`MC_COLS-1:0][`WT_AW-1:0]    wt_col_addr,
	output logic [`MC_COLS-1:0]                wt_col_vld
);
	import mem_ctrl_pkg::*;

	logic               busy;
	logic [`KS_W-1:0]   k_cnt;
	logic [MUL_W-1:0]   n_prod;
	logic [MUL_W-1:0]   m_prod;
	logic [MUL_W-1:0]   total;
	logic [`WT_AW-1:0]  n_off;
	logic [`WT_AW-1:0]  m_off;
	logic [`WT_AW-1:0]  wt_last;
	logic [`WT_AW-1:0]  addr0_nxt;

	// k*m words per fetch group, k words per input map
	assign n_prod = (MUL_W'(ft_n_cnt) - MUL_W'(1)) * MUL_W'(k) * MUL_W'(m);
	assign m_prod = (MUL_W'(m_cnt) - MUL_W'(1)) * MUL_W'(k);
	assign total  = MUL_W'(k) * MUL_W'(m) * MUL_W'(ft_n_times);
	// final weight word of the layer
	assign wt_last = `WT_AW'(MUL_W'(wt_base) + total - MUL_W'(1));

	// burst offsets, captured while the counters still hold the burst
	always_ff @(posedge clk_cal) begin
		if (rd_done) begin
			n_off <= `WT_AW'(n_prod);
			m_off <= `WT_AW'(m_prod);
		end
	end

	// ***********************************************************
	// k-cycle window, restarted by every rd_done
	// ***********************************************************
	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n) begin
			busy  <= 1'b0;
			k_cnt <= '0;
		end else if (cal_start) begin
			busy  <= 1'b0;
			k_cnt <= '0;
		end else if (rd_done) begin
			busy  <= 1'b1;
			k_cnt <= '0;
		end else if (busy) begin
			if (k_cnt == k - 1'b1 || !cal_active)
				busy <= 1'b0;
			k_cnt <= k_cnt + 1'b1;
		end
	end

	assign addr0_nxt = wt_base + n_off + m_off + `WT_AW'(k_cnt);

	// ***********************************************************
	// column 0 and skew line, column i lags column 0 by i cycles
	// ***********************************************************
	always_ff @(posedge clk_cal) begin
		if (cal_start)
			wt_col_addr[0] <= wt_base;
		else if (busy)
			wt_col_addr[0] <= addr0_nxt;
		// back to the layer base once the last word is out and maps flow again
		else if (pe_end && wt_col_addr[0] == wt_last)
			wt_col_addr[0] <= wt_base;
		for (int i = 1; i < `MC_COLS; i++)
			wt_col_addr[i] <= wt_col_addr[i-1];
	end

	always_ff @(posedge clk_cal or negedge rst_cal_n) begin
		if (!rst_cal_n)
			wt_col_vld <= '0;
		else
			wt_col_vld <= {wt_col_vld[`MC_COLS-2:0], busy && cal_active};
	end

endmodule

`default_nettype wire

//--- verilog/mem_ctrl_top.sv
// memory controller top, parameter decode feeding the map read sequencer
// and the weight address generator, connections only
`timescale 1ns/1ps
`default_nettype none
`include "mem_ctrl_defines.svh"

module mem_ctrl_top (
	input  logic                               clk_cal,
	input  logic                               rst_cal_n,
	input  logic [`LYR_W-1:0]                  nn_layer_cnt,
	input  logic                               param_load,
	input  logic                               cal_start,
	input  logic                               cal_active,
	input  logic                               pe_end,
	output logic [`KS_W-1:0]                   k,
	output logic [`KS_W-1:0]                   s,
	output logic [`PK_W-1:0]                   pool_k,
	output logic [`PS_W-1:0]                   pool_s,
	output logic [`RELU_W-1:0]                 relu_max,
	output logic [`CYC_W-1:0]                  cal_cycle,
	output logic [`CYC_W-1:0]                  pass_cycle,
	output logic [`BM_W-1:0]                   bm_cnt,
	output logic [`FTN_W-1:0]                  ft_n_cnt,
	output logic [`MAP_AW-1:0]                 rd_addr,
	output logic                               rd_done,
	output logic                               data_o_vld,
	output logic                               data_o_vld1,
	output logic                               rd_lyr_done,
	output logic [`MC_COLS-1:0][`WT_AW-1:0]    wt_col_addr,
	output logic [`MC_COLS-1:0]                wt_col_vld
);

	// loop bounds from decode
	logic [`CH_W-1:0]   m;
	logic [`SPAN_W-1:0] imap_span;
	logic [`BM_W-1:0]   bm_times;
	logic [`BM_W-1:0]   bm_times1;
	logic [`CAL_W-1:0]  cal_times;
	logic [`FTN_W-1:0]  ft_n_times;
	logic [`WT_AW-1:0]  wt_base;
	// burst position for the weight offsets
	logic [`CH_W-1:0]   m_cnt;

	layer_param_decode u_decode (
		.clk_cal(clk_cal), .rst_cal_n(rst_cal_n),
		.param_load(param_load), .nn_layer_cnt(nn_layer_cnt),
		.k(k), .s(s), .m(m), .pool_k(pool_k), .pool_s(pool_s), .relu_max(relu_max),
		.cal_cycle(cal_cycle), .pass_cycle(pass_cycle), .imap_span(imap_span),
		.bm_times(bm_times), .bm_times1(bm_times1), .cal_times(cal_times),
		.ft_n_times(ft_n_times), .wt_base(wt_base)
	);

	map_read_sequencer u_seq (
		.clk_cal(clk_cal), .rst_cal_n(rst_cal_n),
		.cal_start(cal_start), .cal_active(cal_active), .pe_end(pe_end),
		.imap_span(imap_span), .bm_times(bm_times), .bm_times1(bm_times1),
		.cal_times(cal_times), .ft_n_times(ft_n_times), .m(m), .s(s),
		.bm_cnt(bm_cnt), .m_cnt(m_cnt), .ft_n_cnt(ft_n_cnt), .rd_addr(rd_addr),
		.rd_done(rd_done), .data_o_vld(data_o_vld), .data_o_vld1(data_o_vld1),
		.rd_lyr_done(rd_lyr_done)
	);

	weight_addr_gen u_wt (
		.clk_cal(clk_cal), .rst_cal_n(rst_cal_n),
		.cal_start(cal_start), .cal_active(cal_active), .pe_end(pe_end),
		.rd_done(rd_done), .m_cnt(m_cnt), .ft_n_cnt(ft_n_cnt),
		.k(k), .m(m), .ft_n_times(ft_n_times), .wt_base(wt_base),
		.wt_col_addr(wt_col_addr), .wt_col_vld(wt_col_vld)
	);

endmodule

`default_nettype wire

//--- test/mem_ctrl_assert.sv
// concurrent checks on the read sequencer flags and the weight valid skew line
// attached to every mem_ctrl_top instance by the bind at the end of this file
`timescale 1ns/1ps
`default_nettype none
`include "mem_ctrl_defines.svh"

module mem_ctrl_assert (
	input logic                clk_cal,
	input logic                rst_cal_n,
	input logic                cal_start,
	input logic                rd_done,
	input logic                rd_lyr_done,
	input logic [`MC_COLS-1:0] wt_col_vld
);

	// burst done is a single cycle pulse
	rd_done_pulse: assert property (@(posedge clk_cal) disable iff (!rst_cal_n)
		rd_done |=> !rd_done)
		else $error("rd_done high for more than one cycle");

	// layer done level only drops on a new start
	lyr_done_hold: assert property (@(posedge clk_cal) disable iff (!rst_cal_n)
		(rd_lyr_done && !cal_start) |=> rd_lyr_done)
		else $error("rd_lyr_done dropped without cal_start");

	// ***********************************************************
	// each column valid lags its neighbour by one cycle
	// ***********************************************************
	for (genvar i = 1; i < `MC_COLS; i++) begin : g_col
		col_skew: assert property (@(posedge clk_cal) disable iff (!rst_cal_n)
			wt_col_vld[i] == $past(wt_col_vld[i-1]))
			else $error("wt_col_vld[%0d] does not follow column %0d", i, i - 1);
	end

endmodule

bind mem_ctrl_top mem_ctrl_assert u_assert (
	.clk_cal(clk_cal),
	.rst_cal_n(rst_cal_n),
	.cal_start(cal_start),
	.rd_done(rd_done),
	.rd_lyr_done(rd_lyr_done),
	.wt_col_vld(wt_col_vld)
);

`default_nettype wire

//--- test/mem_ctrl_tb.sv
// table-driven testbench for mem_ctrl_top, runs layers through load, start and read
// a cycle model built from the layer table predicts every checked output
`timescale 1ns/1ps
`default_nettype none
`include "mem_ctrl_defines.svh"

module mem_ctrl_tb;
	import mem_ctrl_pkg::*;

	localparam int NUM_RUNS = 3;
	localparam int MARGIN   = 600;
	// layer, pe_end gaps, expected rd_done pulses per layer
	localparam int run_tbl [0:NUM_RUNS-1][0:2] = '{
		'{1, 2, 113},
		'{3, 3, 336},
		'{7, 4, 576}
	};

	logic                            clk_cal;
	logic                            rst_cal_n;
	logic [`LYR_W-1:0]               nn_layer_cnt;
	logic                            param_load;
	logic                            cal_start;
	logic                            cal_active;
	logic                            pe_end;
	logic [`KS_W-1:0]                k;
	logic [`KS_W-1:0]                s;
	logic [`PK_W-1:0]                pool_k;
	logic [`PS_W-1:0]                pool_s;
	logic [`RELU_W-1:0]              relu_max;
	logic [`CYC_W-1:0]               cal_cycle;
	logic [`CYC_W-1:0]               pass_cycle;
	logic [`BM_W-1:0]                bm_cnt;
	logic [`FTN_W-1:0]               ft_n_cnt;
	logic [`MAP_AW-1:0]              rd_addr;
	logic                            rd_done;
	logic                            data_o_vld;
	logic                            data_o_vld1;
	logic                            rd_lyr_done;
	logic [`MC_COLS-1:0][`WT_AW-1:0] wt_col_addr;
	logic [`MC_COLS-1:0]             wt_col_vld;

	// loop bounds of the loaded layer
	int mb_span, mb_bm, mb_cal, mb_ftn, mb_m, mb_k, mb_s, mb_base;
	// read side model state
	int c_bm, c_m, c_ftn, c_cal;
	bit c_done, c_lyr, started, addr_chk;
	bit e_dvld, e_dvld1;
	int e_addr;
	// weight window model state
	bit w_busy, e_vld0;
	int w_k, w_noff, w_moff, e_addr0;
	// column 0 history, entry j is j+1 cycles old
	bit h_vld [0:`MC_COLS-2];
	int h_addr [0:`MC_COLS-2];
	int n_errors, n_checks, n_bursts, cycles, cycle_limit;
	logic [7:0] lfsr_state;

	mem_ctrl_top dut0 (
		.clk_cal(clk_cal), .rst_cal_n(rst_cal_n), .nn_layer_cnt(nn_layer_cnt),
		.param_load(param_load), .cal_start(cal_start), .cal_active(cal_active),
		.pe_end(pe_end), .k(k), .s(s), .pool_k(pool_k), .pool_s(pool_s),
		.relu_max(relu_max), .cal_cycle(cal_cycle), .pass_cycle(pass_cycle),
		.bm_cnt(bm_cnt), .ft_n_cnt(ft_n_cnt), .rd_addr(rd_addr), .rd_done(rd_done),
		.data_o_vld(data_o_vld), .data_o_vld1(data_o_vld1), .rd_lyr_done(rd_lyr_done),
		.wt_col_addr(wt_col_addr), .wt_col_vld(wt_col_vld)
	);

	initial begin
		clk_cal = 1'b0;
		forever #5 clk_cal = ~clk_cal;
	end

	function automatic int ceil_div(input int a, input int b);
		return (a + b - 1) / b;
	endfunction

	// 8-bit Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] st);
		return {st[6:0], st[7] ^ st[5] ^ st[4] ^ st[3]};
	endfunction

	// n random bits, one LFSR step per bit
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic void load_bounds(input int lyr);
		mb_span = ceil_div(layer_tbl[lyr][LT_IX] + layer_tbl[lyr][LT_PAD], `MC_COLS);
		mb_bm   = ceil_div(layer_tbl[lyr][LT_HU], `MC_COLS);
		mb_ftn  = ceil_div(layer_tbl[lyr][LT_N], `MC_COLS);
		// the last layer runs a single pass
		mb_cal  = (lyr == `NUM_CONV_LAYERS) ? 1 : ceil_div(layer_tbl[lyr][LT_OXC], `MC_ROWS);
		mb_m    = layer_tbl[lyr][LT_M];
		mb_k    = layer_tbl[lyr][LT_K];
		mb_s    = layer_tbl[lyr][LT_S];
		mb_base = wt_base_tbl[lyr];
	endfunction

	// cycle budget of one layer, each burst padded by two cycles
	function automatic int layer_cycles(input int lyr);
		load_bounds(lyr);
		return mb_m * mb_ftn * mb_cal * (mb_bm + 3);
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// one rising edge of the model, inputs as the DUT samples them
	task automatic model_edge();
		bit adv;
		bit b_end;
		bit m_last;
		bit f_last;
		adv    = pe_end && cal_active && !c_lyr;
		b_end  = adv && (c_bm == mb_bm);
		m_last = (c_m == mb_m);
		f_last = (c_ftn == mb_ftn);
		// every word of a burst but the last carries a valid
		e_dvld  = adv && (c_bm != mb_bm);
		e_dvld1 = adv && (c_bm != mb_bm + 1);
		// address uses the counters from before this edge
		addr_chk = pe_end && started && !c_lyr;
		if (addr_chk)
			e_addr = (c_m - 1) * mb_span + (c_cal - 1) * 2 * mb_s + c_bm;
		e_vld0 = w_busy && cal_active;
		if (w_busy)
			e_addr0 = mb_base + w_noff + w_moff + w_k;
		// k word window restarts on each burst done
		if (cal_start) begin
			w_busy = 1'b0;
			w_k    = 0;
		end else if (c_done) begin
			w_busy = 1'b1;
			w_k    = 0;
			w_noff = (c_ftn - 1) * mb_k * mb_m;
			w_moff = (c_m - 1) * mb_k;
		end else if (w_busy) begin
			if (w_k == mb_k - 1 || !cal_active)
				w_busy = 1'b0;
			w_k++;
		end
		// m innermost, then fetch group, then pass
		if (cal_start) begin
			c_m     = 1;
			c_ftn   = 1;
			c_cal   = 1;
			c_lyr   = 1'b0;
			started = 1'b1;
		end else if (c_done) begin
			if (m_last && f_last && c_cal == mb_cal)
				c_lyr = 1'b1;
			if (m_last && f_last && c_cal != mb_cal)
				c_cal++;
			if (m_last)
				c_ftn = f_last ? 1 : c_ftn + 1;
			c_m = m_last ? 1 : c_m + 1;
		end
		c_bm   = (cal_start || b_end || !adv) ? 0 : c_bm + 1;
		c_done = b_end;
		// new bounds only show after this edge
		if (param_load)
			load_bounds(int'(nn_layer_cnt));
	endtask

	task automatic sample_outputs();
		expect_eq("rd_done", 32'(rd_done), 32'(c_done));
		expect_eq("rd_lyr_done", 32'(rd_lyr_done), 32'(c_lyr));
		expect_eq("data_o_vld", 32'(data_o_vld), 32'(e_dvld));
		expect_eq("data_o_vld1", 32'(data_o_vld1), 32'(e_dvld1));
		if (addr_chk)
			expect_eq("rd_addr", 32'(rd_addr), 32'(e_addr));
		if (started) begin
			expect_eq("bm_cnt", 32'(bm_cnt), 32'(c_bm));
			expect_eq("ft_n_cnt", 32'(ft_n_cnt), 32'(c_ftn));
		end
		expect_eq("wt_col_vld[0]", 32'(wt_col_vld[0]), 32'(e_vld0));
		if (e_vld0)
			expect_eq("wt_col_addr[0]", 32'(wt_col_addr[0]), 32'(e_addr0));
		// column i replays column 0 from i cycles back
		for (int i = 1; i < `MC_COLS; i++) begin
			expect_eq($sformatf("wt_col_vld[%0d]", i), 32'(wt_col_vld[i]), 32'(h_vld[i-1]));
			if (h_vld[i-1])
				expect_eq($sformatf("wt_col_addr[%0d]", i), 32'(wt_col_addr[i]),
					32'(h_addr[i-1]));
		end
		for (int j = `MC_COLS - 2; j > 0; j--) begin
			h_vld[j]  = h_vld[j-1];
			h_addr[j] = h_addr[j-1];
		end
		h_vld[0]  = e_vld0;
		h_addr[0] = e_addr0;
		if (rd_done)
			n_bursts++;
	endtask

	// drive on the rising edge, check at the falling edge
	task automatic drive_cycle(input int lyr, input bit pl, input bit cs, input bit ca,
			input bit pe);
		@(posedge clk_cal);
		model_edge();
		nn_layer_cnt <= `LYR_W'(lyr);
		param_load   <= pl;
		cal_start    <= cs;
		cal_active   <= ca;
		pe_end       <= pe;
		@(negedge clk_cal);
		sample_outputs();
		cycles++;
		if (cycles > cycle_limit) begin
			$display("ERROR: no layer end after %0d cycles, run stopped", cycles);
			$display(">>> FAIL");
			$finish;
		end
	endtask

	task automatic verify_idle();
		expect_eq("rd_done", 32'(rd_done), 32'd0);
		expect_eq("data_o_vld", 32'(data_o_vld), 32'd0);
		expect_eq("data_o_vld1", 32'(data_o_vld1), 32'd0);
		expect_eq("rd_lyr_done", 32'(rd_lyr_done), 32'd0);
		expect_eq("wt_col_vld", 32'(wt_col_vld), 32'd0);
	endtask

	task automatic param_compare(input int lyr);
		int pk;
		pk = layer_tbl[lyr][LT_K];
		expect_eq("k", 32'(k), 32'(pk));
		expect_eq("s", 32'(s), 32'(layer_tbl[lyr][LT_S]));
		expect_eq("pool_k", 32'(pool_k), 32'(layer_tbl[lyr][LT_PK]));
		expect_eq("pool_s", 32'(pool_s), 32'(layer_tbl[lyr][LT_PS]));
		expect_eq("relu_max", 32'(relu_max), 32'(layer_tbl[lyr][LT_RELU]));
		expect_eq("cal_cycle", 32'(cal_cycle), 32'(pk * layer_tbl[lyr][LT_M]));
		expect_eq("pass_cycle", 32'(pass_cycle), 32'(`MC_ROWS + `MC_COLS + pk - 3));
	endtask

	initial begin
		int lyr;
		int gaps;
		int next_gap;
		int lyr_cyc;
		bit pe;
		rst_cal_n    = 1'b0;
		nn_layer_cnt = '0;
		param_load   = 1'b0;
		cal_start    = 1'b0;
		cal_active   = 1'b0;
		pe_end       = 1'b0;
		lfsr_state   = 8'd27;
		for (int j = 0; j < `MC_COLS - 1; j++) begin
			h_vld[j]  = 1'b0;
			h_addr[j] = 0;
		end
		cycle_limit = MARGIN;
		for (int r = 0; r < NUM_RUNS; r++)
			cycle_limit += layer_cycles(run_tbl[r][0]);
		// bounds are zero until the first load, like the DUT after reset
		{mb_span, mb_bm, mb_cal, mb_ftn, mb_m, mb_k, mb_s, mb_base} = '0;

		repeat (5) begin
			@(posedge clk_cal);
			@(negedge clk_cal);
			verify_idle();
		end
		@(posedge clk_cal);
		rst_cal_n <= 1'b1;
		@(negedge clk_cal);
		verify_idle();

		for (int r = 0; r < NUM_RUNS; r++) begin
			lyr  = run_tbl[r][0];
			gaps = run_tbl[r][1];
			drive_cycle(lyr, 1'b1, 1'b0, 1'b0, 1'b0);
			drive_cycle(lyr, 1'b0, 1'b0, 1'b0, 1'b0);
			param_compare(lyr);
			drive_cycle(lyr, 1'b0, 1'b1, 1'b0, 1'b0);
			n_bursts = 0;
			lyr_cyc  = 0;
			next_gap = 8 + take_bits(6);
			// first pass samples the start strobe and clears the old done level
			do begin
				pe = 1'b1;
				if (gaps > 0 && lyr_cyc == next_gap) begin
					pe       = 1'b0;
					gaps     = gaps - 1;
					next_gap = lyr_cyc + 20 + take_bits(7);
				end
				drive_cycle(lyr, 1'b0, 1'b0, 1'b1, pe);
				lyr_cyc++;
			end while (!rd_lyr_done);
			expect_eq("rd_done pulses", 32'(n_bursts), 32'(run_tbl[r][2]));
			// let the last weight window drain, then go idle
			repeat (20)
				drive_cycle(lyr, 1'b0, 1'b0, 1'b1, 1'b1);
			repeat (4)
				drive_cycle(lyr, 1'b0, 1'b0, 1'b0, 1'b0);
		end

		$display("errors: %0d, checks: %0d", n_errors, n_checks);
		if (n_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/mem_ctrl_pkg.sv
verilog/layer_param_decode.sv
verilog/map_read_sequencer.sv
verilog/weight_addr_gen.sv
verilog/mem_ctrl_top.sv
test/mem_ctrl_assert.sv
test/mem_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# build and run the memory controller testbench with Verilator, output in sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module mem_ctrl_tb \
	-f list.f -o mem_ctrl_sim > sim.log 2>&1 \
	&& ./obj_dir/mem_ctrl_sim >> sim.log 2>&1 \
	|| echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && echo "simulation failed" && exit 1
echo "simulation passed"
exit 0
